/* Bender.yml */
package:
  name: player_mask

sources:
  # packages first, then leaf modules, then the top level
  - rtl/video_pkg.sv
  - rtl/mask_pkg.sv
  - rtl/pixel_unpacker.sv
  - rtl/channel_threshold.sv
  - rtl/player_mask_combiner.sv
  - rtl/player_mask_top.sv

  # testbench
  - target: test
    files:
      - tests/tb_player_mask.sv

/* rtl/channel_threshold.sv */
module channel_threshold (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  mask_pkg::channel_t  value_i,
  input  mask_pkg::channel_t  lower_i,
  input  mask_pkg::channel_t  upper_i,
  output logic                in_range_o
);

  // ================================================
  // inclusive window compare
  // ================================================

  logic above_lower;
  logic below_upper;

  // both edges count as inside
  assign above_lower = (value_i >= lower_i);
  assign below_upper = (value_i <= upper_i);

  // lower above upper gives an empty window
  // so such a lane never passes

  // one register stage, matches the combiner alignment
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      in_range_o <= 1'b0;
    end else begin
      in_range_o <= above_lower && below_upper;
    end
  end

endmodule

/* rtl/mask_pkg.sv */
package mask_pkg;

  // ================================================
  // color lanes
  // ================================================

  // lane index, one thresholder per lane
  typedef enum logic [1:0] {
    CH_RED,
    CH_GREEN,
    CH_BLUE
  } channel_e;

  // number of lanes in the mask path
  localparam int NUM_CHANNELS = 3;

  // one widened 8-bit color channel
  typedef logic [7:0] channel_t;

  // per-lane bound values, indexed by channel_e
  typedef channel_t bounds_t [NUM_CHANNELS];

  // ================================================
  // frame statistics
  // ================================================

  // player pixels per frame
  // 2^21 covers a full 1280x720 frame
  typedef logic [20:0] count_t;

endpackage

/* rtl/pixel_unpacker.sv */
module pixel_unpacker #(
  parameter int SCREEN_WIDTH = video_pkg::DEFAULT_SCREEN_WIDTH,
  parameter int SCREEN_HEIGHT = video_pkg::DEFAULT_SCREEN_HEIGHT
) (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  logic                pixel_valid_i,
  input  video_pkg::rgb565_t  pixel_i,
  input  video_pkg::hcount_t  hcount_i,
  input  video_pkg::vcount_t  vcount_i,
  output logic                valid_o,
  output logic                last_o,
  output mask_pkg::channel_t  chan_o [mask_pkg::NUM_CHANNELS],
  output video_pkg::hcount_t  hcount_o,
  output video_pkg::vcount_t  vcount_o
);

  // coordinates of the final pixel in a frame
  localparam video_pkg::hcount_t LAST_HCOUNT = video_pkg::hcount_t'(SCREEN_WIDTH - 1);
  localparam video_pkg::vcount_t LAST_VCOUNT = video_pkg::vcount_t'(SCREEN_HEIGHT - 1);

  logic at_frame_end;

  // bottom right corner of the active area
  assign at_frame_end = (hcount_i == LAST_HCOUNT) && (vcount_i == LAST_VCOUNT);

  // strobe and frame-end flag
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      valid_o <= 1'b0;
      last_o <= 1'b0;
    end else begin
      valid_o <= pixel_valid_i;
      // only a real pixel can close the frame
      last_o <= pixel_valid_i && at_frame_end;
    end
  end

  // widen 5:6:5 into 8:8:8
  // low bits zero filled, no rounding
  always_ff @(posedge clk_camera) begin
    if (pixel_valid_i) begin
      chan_o[mask_pkg::CH_RED] <= {pixel_i.red, 3'b000};
      chan_o[mask_pkg::CH_GREEN] <= {pixel_i.green, 2'b00};
      chan_o[mask_pkg::CH_BLUE] <= {pixel_i.blue, 3'b000};
      // coordinates ride along with the channels
      hcount_o <= hcount_i;
      vcount_o <= vcount_i;
    end
  end

endmodule

/* rtl/player_mask_combiner.sv */
module player_mask_combiner (
  input  logic                                clk_camera,
  input  logic                                recent_reset,
  input  logic                                valid_i,
  input  logic                                last_i,
  input  video_pkg::hcount_t                  hcount_i,
  input  video_pkg::vcount_t                  vcount_i,
  input  logic [mask_pkg::NUM_CHANNELS-1:0]   in_range_i,
  output logic                                mask_valid_o,
  output logic                                mask_o,
  output video_pkg::hcount_t                  hcount_o,
  output video_pkg::vcount_t                  vcount_o,
  output mask_pkg::count_t                    frame_count_o,
  output logic                                frame_done_o
);

  // ================================================
  // alignment with the lane results
  // ================================================

  logic valid_q;
  logic last_q;
  logic player_px;
  logic frame_end;
  mask_pkg::count_t running_count;
  mask_pkg::count_t next_count;

  // thresholders add one stage, so delay the side signals by one
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      valid_q <= 1'b0;
      last_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
      last_q <= valid_i && last_i;
    end
  end

  // coordinates only move with a pixel
  always_ff @(posedge clk_camera) begin
    if (valid_i) begin
      hcount_o <= hcount_i;
      vcount_o <= vcount_i;
    end
  end

  // player pixel needs every lane inside its window
  assign mask_o = &in_range_i;
  assign mask_valid_o = valid_q;

  // ================================================
  // per-frame player pixel count
  // ================================================

  // only qualified pixels add to the count
  assign player_px = valid_q && mask_o;
  assign frame_end = valid_q && last_q;

  // running total including the pixel now at the output
  assign next_count = running_count + mask_pkg::count_t'(player_px);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      running_count <= '0;
      frame_done_o <= 1'b0;
    end else begin
      // one cycle pulse on the aligned last pixel
      frame_done_o <= frame_end;
      if (frame_end) begin
        // next frame starts from zero
        running_count <= '0;
      end else begin
        running_count <= next_count;
      end
    end
  end

  // final count, last pixel included
  always_ff @(posedge clk_camera) begin
    if (frame_end) begin
      frame_count_o <= next_count;
    end
  end

endmodule

/* rtl/player_mask_top.sv */
module player_mask_top #(
  parameter int SCREEN_WIDTH = video_pkg::DEFAULT_SCREEN_WIDTH,
  parameter int SCREEN_HEIGHT = video_pkg::DEFAULT_SCREEN_HEIGHT
) (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  logic                pixel_valid_i,
  input  video_pkg::rgb565_t  pixel_i,
  input  video_pkg::hcount_t  hcount_i,
  input  video_pkg::vcount_t  vcount_i,
  input  mask_pkg::bounds_t   lower_bound_i,
  input  mask_pkg::bounds_t   upper_bound_i,
  output logic                mask_valid_o,
  output logic                mask_o,
  output video_pkg::hcount_t  hcount_o,
  output video_pkg::vcount_t  vcount_o,
  output mask_pkg::count_t    frame_count_o,
  output logic                frame_done_o
);

  // unpacker to lanes and combiner
  logic                                 unpack_valid;
  logic                                 unpack_last;
  mask_pkg::channel_t                   unpack_chan [mask_pkg::NUM_CHANNELS];
  video_pkg::hcount_t                   unpack_hcount;
  video_pkg::vcount_t                   unpack_vcount;
  // one result bit per lane
  wire logic [mask_pkg::NUM_CHANNELS-1:0] lane_in_range;

  // ================================================
  // rgb565 to three 8-bit lanes
  // ================================================
  pixel_unpacker #(
    .SCREEN_WIDTH(SCREEN_WIDTH),
    .SCREEN_HEIGHT(SCREEN_HEIGHT)
  ) i_unpacker (
    .clk_camera(clk_camera),
    .recent_reset(recent_reset),
    .pixel_valid_i(pixel_valid_i),
    .pixel_i(pixel_i),
    .hcount_i(hcount_i),
    .vcount_i(vcount_i),
    .valid_o(unpack_valid),
    .last_o(unpack_last),
    .chan_o(unpack_chan),
    .hcount_o(unpack_hcount),
    .vcount_o(unpack_vcount)
  );

  // one thresholder per color lane
  for (genvar lane = int'(mask_pkg::CH_RED); lane <= int'(mask_pkg::CH_BLUE);
       lane++) begin : g_lane
    channel_threshold i_threshold (
      .clk_camera(clk_camera),
      .recent_reset(recent_reset),
      .value_i(unpack_chan[lane]),
      .lower_i(lower_bound_i[lane]),
      .upper_i(upper_bound_i[lane]),
      .in_range_o(lane_in_range[lane])
    );
  end

  // ================================================
  // lane merge and frame statistics
  // ================================================
  player_mask_combiner i_combiner (
    .clk_camera(clk_camera),
    .recent_reset(recent_reset),
    .valid_i(unpack_valid),
    .last_i(unpack_last),
    .hcount_i(unpack_hcount),
    .vcount_i(unpack_vcount),
    .in_range_i(lane_in_range),
    .mask_valid_o(mask_valid_o),
    .mask_o(mask_o),
    .hcount_o(hcount_o),
    .vcount_o(vcount_o),
    .frame_count_o(frame_count_o),
    .frame_done_o(frame_done_o)
  );

endmodule

/* rtl/video_pkg.sv */
package video_pkg;

  // ================================================
  // camera pixel format
  // ================================================

  // rgb565 word as it comes off the camera path
  // red in the top five bits, blue in the bottom five
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // ================================================
  // screen geometry
  // ================================================

  // horizontal position, wide enough for 1280 columns
  typedef logic [10:0] hcount_t;

  // vertical position, wide enough for 720 lines
  typedef logic [9:0] vcount_t;

  // default active frame size, 720p
  localparam int DEFAULT_SCREEN_WIDTH = 1280;
  localparam int DEFAULT_SCREEN_HEIGHT = 720;

endpackage

/* src.f */
rtl/video_pkg.sv
rtl/mask_pkg.sv
rtl/pixel_unpacker.sv
rtl/channel_threshold.sv
rtl/player_mask_combiner.sv
rtl/player_mask_top.sv
tests/tb_player_mask.sv

/* tests/tb_player_mask.sv */
module tb_player_mask;

  // ================================================
  // run setup
  // ================================================

  // small frame so frame ends come often
  localparam int SCREEN_WIDTH = 8;
  localparam int SCREEN_HEIGHT = 4;
  localparam int PIXELS_PER_FRAME = SCREEN_WIDTH * SCREEN_HEIGHT;
  localparam int NUM_FRAMES = 6;
  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 8;
  // at most four cycles per pixel, then a margin of 100 cycles
  localparam int TIMEOUT_TIME =
      NUM_FRAMES * PIXELS_PER_FRAME * 4 * CLK_PERIOD + 100 * CLK_PERIOD;

  logic               clk_camera;
  logic               recent_reset;
  logic               pixel_valid_i;
  video_pkg::rgb565_t pixel_i;
  video_pkg::hcount_t hcount_i;
  video_pkg::vcount_t vcount_i;
  mask_pkg::bounds_t  lower_bound_i;
  mask_pkg::bounds_t  upper_bound_i;
  logic               mask_valid_o;
  logic               mask_o;
  video_pkg::hcount_t hcount_o;
  video_pkg::vcount_t vcount_o;
  mask_pkg::count_t   frame_count_o;
  logic               frame_done_o;

  // lcg state
  logic [31:0] rng_state;
  // falling edges seen so far
  int cyc;
  int cur_test;
  int check_count;
  int error_count;
  int tests_run;
  int tests_failed;
  // test 0 is reset, then one test per frame
  int test_errors [NUM_FRAMES + 1];
  // bound fields of the current frame, in rgb565 units
  int lo_field [mask_pkg::NUM_CHANNELS];
  int hi_field [mask_pkg::NUM_CHANNELS];
  // model count of the frame being driven
  mask_pkg::count_t model_count;

  // expected per-pixel results, oldest first
  int                 pix_due_q [$];
  logic               pix_mask_q [$];
  video_pkg::hcount_t pix_h_q [$];
  video_pkg::vcount_t pix_v_q [$];
  int                 pix_test_q [$];
  // expected frame counts
  int                 cnt_due_q [$];
  mask_pkg::count_t   cnt_val_q [$];
  int                 cnt_test_q [$];

  player_mask_top #(
    .SCREEN_WIDTH(SCREEN_WIDTH),
    .SCREEN_HEIGHT(SCREEN_HEIGHT)
  ) i_dut (
    .clk_camera(clk_camera),
    .recent_reset(recent_reset),
    .pixel_valid_i(pixel_valid_i),
    .pixel_i(pixel_i),
    .hcount_i(hcount_i),
    .vcount_i(vcount_i),
    .lower_bound_i(lower_bound_i),
    .upper_bound_i(upper_bound_i),
    .mask_valid_o(mask_valid_o),
    .mask_o(mask_o),
    .hcount_o(hcount_o),
    .vcount_o(vcount_o),
    .frame_count_o(frame_count_o),
    .frame_done_o(frame_done_o)
  );

  initial begin
    clk_camera = 1'b0;
    forever #(CLK_PERIOD / 2) clk_camera = ~clk_camera;
  end

  // watchdog
  initial begin
    #(TIMEOUT_TIME);
    $display("run timed out after %0d time units", TIMEOUT_TIME);
    $display("Verification failed");
    $finish;
  end

  // ================================================
  // random numbers and reference model
  // ================================================

  function automatic logic [15:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    // upper half has the better period
    return rng_state[31:16];
  endfunction

  function automatic int rand_below(int n);
    return int'(next_rand()) % n;
  endfunction

  // green keeps six bits, red and blue five
  function automatic int field_width(int lane);
    return (lane == int'(mask_pkg::CH_GREEN)) ? 6 : 5;
  endfunction

  // field on top, zeros below
  function automatic mask_pkg::channel_t widen(int field, int lane);
    return mask_pkg::channel_t'(field << (8 - field_width(lane)));
  endfunction

  function automatic string test_name(int t);
    return (t == 0) ? "reset" : $sformatf("frame_%0d", t);
  endfunction

  // ================================================
  // checks and report
  // ================================================

  task automatic report_error(input int t, input string msg);
    error_count++;
    test_errors[t]++;
    $display("%s: %s", test_name(t), msg);
  endtask

  task automatic compare_mask(input int t, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      test_errors[t]++;
      $display("FAILED %s mask: expected %0b actual %0b", test_name(t), exp, act);
    end
  endtask

  task automatic compare_coord(input int t, input video_pkg::hcount_t exp_h,
                               input video_pkg::vcount_t exp_v,
                               input video_pkg::hcount_t act_h,
                               input video_pkg::vcount_t act_v);
    check_count++;
    if (act_h !== exp_h || act_v !== exp_v) begin
      error_count++;
      test_errors[t]++;
      $display("FAILED %s coord: expected (%0d,%0d) actual (%0d,%0d)",
               test_name(t), exp_h, exp_v, act_h, act_v);
    end
  endtask

  task automatic compare_count(input int t, input mask_pkg::count_t exp,
                               input mask_pkg::count_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      test_errors[t]++;
      $display("FAILED %s count: expected %0d actual %0d", test_name(t), exp, act);
    end
  endtask

  task automatic finish_test(input int t);
    tests_run++;
    if (test_errors[t] != 0) begin
      tests_failed++;
    end
    $display("%s finished with %0d errors", test_name(t), test_errors[t]);
  endtask

  // outputs are stable at the falling edge
  task automatic check_outputs();
    int t;
    logic exp_mask;
    video_pkg::hcount_t exp_h;
    video_pkg::vcount_t exp_v;
    mask_pkg::count_t exp_cnt;
    if (pix_due_q.size() > 0 && pix_due_q[0] == cyc) begin
      pix_due_q.delete(0);
      t = pix_test_q.pop_front();
      exp_mask = pix_mask_q.pop_front();
      exp_h = pix_h_q.pop_front();
      exp_v = pix_v_q.pop_front();
      if (mask_valid_o !== 1'b1) begin
        report_error(t, $sformatf("mask_valid_o stayed low for pixel (%0d,%0d)", exp_h, exp_v));
      end else begin
        compare_mask(t, exp_mask, mask_o);
        compare_coord(t, exp_h, exp_v, hcount_o, vcount_o);
      end
    end else if (mask_valid_o !== 1'b0) begin
      report_error(cur_test, "mask_valid_o was high with no pixel due");
    end
    // frame end, three cycles after the last pixel
    if (cnt_due_q.size() > 0 && cnt_due_q[0] == cyc) begin
      cnt_due_q.delete(0);
      t = cnt_test_q.pop_front();
      exp_cnt = cnt_val_q.pop_front();
      if (frame_done_o !== 1'b1) begin
        report_error(t, "frame_done_o did not pulse after the last pixel");
      end else begin
        compare_count(t, exp_cnt, frame_count_o);
      end
      finish_test(t);
    end else if (frame_done_o !== 1'b0) begin
      report_error(cur_test, "frame_done_o pulsed with no frame end due");
    end
  endtask

  // ================================================
  // stimulus
  // ================================================

  task automatic step();
    @(negedge clk_camera);
    cyc++;
    check_outputs();
  endtask

  // idle coordinates often hit the frame corner, strobe low
  task automatic drive_idle();
    step();
    pixel_valid_i = 1'b0;
    pixel_i = video_pkg::rgb565_t'(next_rand());
    hcount_i = video_pkg::hcount_t'(rand_below(SCREEN_WIDTH));
    vcount_i = video_pkg::vcount_t'(rand_below(SCREEN_HEIGHT));
  endtask

  // sorted pair per lane, on the widened grid
  task automatic draw_bounds();
    int a;
    int b;
    for (int lane = 0; lane < mask_pkg::NUM_CHANNELS; lane++) begin
      a = rand_below(1 << field_width(lane));
      b = rand_below(1 << field_width(lane));
      lo_field[lane] = (a < b) ? a : b;
      hi_field[lane] = (a < b) ? b : a;
      lower_bound_i[lane] = widen(lo_field[lane], lane);
      upper_bound_i[lane] = widen(hi_field[lane], lane);
    end
  endtask

  // edges, one step outside, or anywhere
  function automatic int pick_field(int lane);
    int fmask;
    fmask = (1 << field_width(lane)) - 1;
    case (rand_below(8))
      0: return rand_below(fmask + 1);
      1: return lo_field[lane];
      2: return hi_field[lane];
      3: return (lo_field[lane] - 1) & fmask;
      4: return (hi_field[lane] + 1) & fmask;
      default: return lo_field[lane] + rand_below(hi_field[lane] - lo_field[lane] + 1);
    endcase
  endfunction

  task automatic drive_pixel(input int h, input int v);
    int field [mask_pkg::NUM_CHANNELS];
    logic exp_mask;
    mask_pkg::channel_t chan;
    step();
    exp_mask = 1'b1;
    for (int lane = 0; lane < mask_pkg::NUM_CHANNELS; lane++) begin
      field[lane] = pick_field(lane);
      chan = widen(field[lane], lane);
      // inclusive window on every lane
      if (chan < lower_bound_i[lane] || chan > upper_bound_i[lane]) begin
        exp_mask = 1'b0;
      end
    end
    pixel_valid_i = 1'b1;
    pixel_i.red = 5'(field[int'(mask_pkg::CH_RED)]);
    pixel_i.green = 6'(field[int'(mask_pkg::CH_GREEN)]);
    pixel_i.blue = 5'(field[int'(mask_pkg::CH_BLUE)]);
    hcount_i = video_pkg::hcount_t'(h);
    vcount_i = video_pkg::vcount_t'(v);
    pix_due_q.push_back(cyc + 2);
    pix_mask_q.push_back(exp_mask);
    pix_h_q.push_back(video_pkg::hcount_t'(h));
    pix_v_q.push_back(video_pkg::vcount_t'(v));
    pix_test_q.push_back(cur_test);
    if (exp_mask) begin
      model_count++;
    end
    // the frame's last pixel closes the count
    if (h == SCREEN_WIDTH - 1 && v == SCREEN_HEIGHT - 1) begin
      cnt_due_q.push_back(cyc + 3);
      cnt_val_q.push_back(model_count);
      cnt_test_q.push_back(cur_test);
      model_count = '0;
    end
  endtask

  initial begin
    rng_state = 32'd49248;
    cyc = 0;
    cur_test = 0;
    check_count = 0;
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    model_count = '0;
    for (int t = 0; t <= NUM_FRAMES; t++) begin
      test_errors[t] = 0;
    end
    recent_reset = 1'b1;
    // strobe held high on the frame corner, reset must hold it off
    pixel_valid_i = 1'b1;
    pixel_i = '0;
    hcount_i = video_pkg::hcount_t'(SCREEN_WIDTH - 1);
    vcount_i = video_pkg::vcount_t'(SCREEN_HEIGHT - 1);
    for (int lane = 0; lane < mask_pkg::NUM_CHANNELS; lane++) begin
      lower_bound_i[lane] = '0;
      upper_bound_i[lane] = '0;
    end
    // empty queues, so both strobes must stay low
    repeat (RESET_CYCLES) step();
    pixel_valid_i = 1'b0;
    recent_reset = 1'b0;
    finish_test(0);
    for (int f = 1; f <= NUM_FRAMES; f++) begin
      // last pixel of the previous frame must clear the thresholders first
      if (f > 1) begin
        drive_idle();
        drive_idle();
      end
      cur_test = f;
      draw_bounds();
      for (int v = 0; v < SCREEN_HEIGHT; v++) begin
        for (int h = 0; h < SCREEN_WIDTH; h++) begin
          repeat (rand_below(4)) drive_idle();
          drive_pixel(h, v);
        end
      end
    end
    // drain the pipeline
    repeat (6) drive_idle();
    if (pix_due_q.size() != 0 || cnt_due_q.size() != 0) begin
      report_error(cur_test, "some expected outputs never appeared");
    end
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
